/* rtl/dcache_pkg.sv */
package dcache_pkg;

  // ======================================================================
  // Widths and address fields
  // ======================================================================
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = DATA_W * LINE_WORDS;
  localparam int INDEX_W    = 5;
  localparam int LINES      = 1 << INDEX_W;
  localparam int TAG_W      = 23;

  // Low bit of each address field
  localparam int WORD_LSB  = 2;
  localparam int INDEX_LSB = 4;
  localparam int TAG_LSB   = 9;

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [1:0]        size_t;

  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  // ======================================================================
  // Shared structs
  // ======================================================================
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
    size_t             size;
  } core_cmd_t;

  typedef struct packed {
    tag_t               tag;
    logic [INDEX_W-1:0] index;
    logic [1:0]         word;
    logic               write;
    size_t              size;
    logic [DATA_W-1:0]  wdata;
    logic [3:0]         byte_en;
  } dec_req_t;

  typedef struct packed {
    logic              req;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    size_t             size;
  } mem_req_t;

  typedef struct packed {
    logic              beat;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // One-cycle flags from the controller
  typedef struct packed {
    logic load_hit;
    logic load_refill;
    logic read_hit;
    logic write_hit;
    logic read_miss;
    logic write_miss;
  } ctrl_evt_t;

  typedef struct packed {
    logic [15:0] read_hits;
    logic [15:0] write_hits;
    logic [15:0] read_misses;
    logic [15:0] write_misses;
  } dcache_stats_t;

endpackage

/* rtl/dcache_array.sv */
`timescale 1ns/100ps

module dcache_array
  import dcache_pkg::*;
#(
  parameter type payload_t = logic [DATA_W-1:0]
) (
  input  logic               clk,
  input  logic [INDEX_W-1:0] index,
  input  logic               wen,
  input  payload_t           wdata,
  output payload_t           rdata
);

  payload_t mem [LINES];

  // Read returns the old entry on a same-cycle write
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[index] <= wdata;
    end
    rdata <= mem[index];
  end

endmodule

/* rtl/dcache_req_decode.sv */
`timescale 1ns/100ps

module dcache_req_decode
  import dcache_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               accept,
  input  core_cmd_t          core_cmd,
  output dec_req_t           req,
  output logic [INDEX_W-1:0] lookup_index
);

  logic [1:0] byte_off;
  logic [3:0] byte_en;

  assign byte_off = core_cmd.addr[WORD_LSB-1:0];

  // Lane enables follow the store data placement
  always_comb begin
    case (core_cmd.size)
      SIZE_BYTE: begin
        byte_en = 4'b0001 << byte_off;
      end
      SIZE_HALF: begin
        byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        byte_en = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      req <= '0;
    end else if (accept) begin
      req.tag     <= core_cmd.addr[ADDR_W-1:TAG_LSB];
      req.index   <= core_cmd.addr[TAG_LSB-1:INDEX_LSB];
      req.word    <= core_cmd.addr[INDEX_LSB-1:WORD_LSB];
      req.write   <= core_cmd.write;
      req.size    <= core_cmd.size;
      req.wdata   <= core_cmd.wdata;
      req.byte_en <= byte_en;
    end
  end

  // Arrays look up the incoming line while the request is taken
  assign lookup_index = accept ? core_cmd.addr[TAG_LSB-1:INDEX_LSB] : req.index;

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               core_req,
  input  logic [INDEX_W-1:0] core_valid_hit_index,
  input  dec_req_t           req,
  input  tag_t               tag_rdata,
  input  line_t              line_rdata,
  output logic               accept,
  output logic               core_wait,
  output logic               tag_wen,
  output tag_t               tag_wdata,
  output logic               line_wen,
  output line_t              line_wdata,
  output line_t              refill_line,
  output mem_req_t           mem_req,
  input  mem_rsp_t           mem_rsp,
  output ctrl_evt_t          evt
);

  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    WHIT,
    WMISS,
    RMISS
  } state_t;

  state_t state, next_state;

  logic [LINES-1:0] valid;
  logic [2:0]       beat_cnt;
  logic             tag_hit;
  logic             refill_done;
  logic             read_miss;
  logic [1:0]       byte_off;
  line_t            merged_line;

  assign accept      = core_req && (state == IDLE);
  assign core_wait   = (state != IDLE);
  assign tag_hit     = (tag_rdata == req.tag);
  assign refill_done = (beat_cnt == 3'(LINE_WORDS));

  // A store on an invalid line lands in RMISS for one cycle and moves on
  assign read_miss = (state == RMISS) && !req.write;

  // ======================================================================
  // State machine
  // ======================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          next_state = valid[core_valid_hit_index] ? CHECK : RMISS;
        end
      end
      CHECK: begin
        if (req.write) begin
          next_state = tag_hit ? WHIT : WMISS;
        end else begin
          next_state = tag_hit ? IDLE : RMISS;
        end
      end
      WHIT, WMISS: begin
        if (mem_rsp.beat) begin
          next_state = IDLE;
        end
      end
      RMISS: begin
        if (req.write) begin
          next_state = WMISS;
        end else if (refill_done) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // Beat counter cleared between requests
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= '0;
    end else if (state == IDLE) begin
      beat_cnt <= '0;
    end else if (read_miss && mem_rsp.beat) begin
      beat_cnt <= beat_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (read_miss && refill_done) begin
      valid[req.index] <= 1'b1;
    end
  end

  // Word 0 arrives first and ends up in the low bits
  always_ff @(posedge clk) begin
    if (read_miss && mem_rsp.beat) begin
      refill_line <= {mem_rsp.rdata, refill_line[LINE_W-1:DATA_W]};
    end
  end

  // ======================================================================
  // Array writes
  // ======================================================================
  always_comb begin
    merged_line = line_rdata;
    for (int b = 0; b < 4; b++) begin
      if (req.byte_en[b]) begin
        merged_line[req.word*DATA_W + b*8 +: 8] = req.wdata[b*8 +: 8];
      end
    end
  end

  assign tag_wen    = read_miss && refill_done;
  assign tag_wdata  = req.tag;
  assign line_wen   = (read_miss && refill_done) || ((state == WHIT) && mem_rsp.beat);
  assign line_wdata = (state == WHIT) ? merged_line : refill_line;

  // ======================================================================
  // Memory request
  // ======================================================================
  // Byte offset recovered from the lane enables
  assign byte_off[1] = !(req.byte_en[0] || req.byte_en[1]);
  assign byte_off[0] = (req.size == SIZE_BYTE) && (req.byte_en[1] || req.byte_en[3]);

  always_comb begin
    mem_req = '0;
    case (state)
      WHIT, WMISS: begin
        mem_req.req   = !mem_rsp.beat;
        mem_req.write = 1'b1;
        mem_req.addr  = {req.tag, req.index, req.word, byte_off};
        mem_req.wdata = req.wdata;
        mem_req.size  = req.size;
      end
      RMISS: begin
        mem_req.req  = read_miss && (beat_cnt == '0) && !mem_rsp.beat;
        mem_req.addr = {req.tag, req.index, {INDEX_LSB{1'b0}}};
        mem_req.size = SIZE_WORD;
      end
      default: begin
        mem_req = '0;
      end
    endcase
  end

  always_comb begin
    evt             = '0;
    evt.load_hit    = (state == CHECK) && !req.write && tag_hit;
    evt.read_hit    = evt.load_hit;
    evt.load_refill = read_miss && refill_done;
    evt.read_miss   = evt.load_refill;
    evt.write_hit   = (state == WHIT) && mem_rsp.beat;
    evt.write_miss  = (state == WMISS) && mem_rsp.beat;
  end

endmodule

/* rtl/dcache_result.sv */
`timescale 1ns/100ps

module dcache_result
  import dcache_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  ctrl_evt_t         evt,
  input  logic [1:0]        word,
  input  line_t             line_rdata,
  input  line_t             refill_line,
  output logic [DATA_W-1:0] core_rdata,
  output dcache_stats_t     stats
);

  logic [DATA_W-1:0] hit_word;
  logic [DATA_W-1:0] refill_word;

  assign hit_word    = line_rdata[word*DATA_W +: DATA_W];
  assign refill_word = refill_line[word*DATA_W +: DATA_W];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      core_rdata <= '0;
    end else if (evt.load_hit) begin
      core_rdata <= hit_word;
    end else if (evt.load_refill) begin
      core_rdata <= refill_word;
    end
  end

  // Counters wrap at 16 bits
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stats <= '0;
    end else begin
      if (evt.read_hit) begin
        stats.read_hits <= stats.read_hits + 16'd1;
      end
      if (evt.write_hit) begin
        stats.write_hits <= stats.write_hits + 16'd1;
      end
      if (evt.read_miss) begin
        stats.read_misses <= stats.read_misses + 16'd1;
      end
      if (evt.write_miss) begin
        stats.write_misses <= stats.write_misses + 16'd1;
      end
    end
  end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              core_req,
  input  core_cmd_t         core_cmd,
  output logic              core_wait,
  output logic [DATA_W-1:0] core_rdata,
  output mem_req_t          mem_req,
  input  mem_rsp_t          mem_rsp,
  output dcache_stats_t     stats
);

  logic               accept;
  dec_req_t           req;
  logic [INDEX_W-1:0] lookup_index;
  logic               tag_wen;
  tag_t               tag_wdata;
  tag_t               tag_rdata;
  logic               line_wen;
  line_t              line_wdata;
  line_t              line_rdata;
  line_t              refill_line;
  ctrl_evt_t          evt;

  // ======================================================================
  // Decode
  // ======================================================================
  dcache_req_decode u_decode (
    .clk          (clk),
    .rstn         (rstn),
    .accept       (accept),
    .core_cmd     (core_cmd),
    .req          (req),
    .lookup_index (lookup_index)
  );

  // ======================================================================
  // Execute
  // ======================================================================
  dcache_ctrl u_ctrl (
    .clk                  (clk),
    .rstn                 (rstn),
    .core_req             (core_req),
    .core_valid_hit_index (core_cmd.addr[TAG_LSB-1:INDEX_LSB]),
    .req                  (req),
    .tag_rdata            (tag_rdata),
    .line_rdata           (line_rdata),
    .accept               (accept),
    .core_wait            (core_wait),
    .tag_wen              (tag_wen),
    .tag_wdata            (tag_wdata),
    .line_wen             (line_wen),
    .line_wdata           (line_wdata),
    .refill_line          (refill_line),
    .mem_req              (mem_req),
    .mem_rsp              (mem_rsp),
    .evt                  (evt)
  );

  dcache_array #(.payload_t(tag_t)) u_tag_array (
    .clk   (clk),
    .index (lookup_index),
    .wen   (tag_wen),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

  dcache_array #(.payload_t(line_t)) u_line_array (
    .clk   (clk),
    .index (lookup_index),
    .wen   (line_wen),
    .wdata (line_wdata),
    .rdata (line_rdata)
  );

  // ======================================================================
  // Result
  // ======================================================================
  dcache_result u_result (
    .clk         (clk),
    .rstn        (rstn),
    .evt         (evt),
    .word        (req.word),
    .line_rdata  (line_rdata),
    .refill_line (refill_line),
    .core_rdata  (core_rdata),
    .stats       (stats)
  );

endmodule

/* verification/dcache_tb_mem.sv */
`timescale 1ns/100ps

module dcache_tb_mem
  import dcache_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  logic [31:0] store [1024];
  logic [31:0] rng;
  logic        busy;
  logic [2:0]  left;
  logic [1:0]  gap;
  logic [1:0]  beat_word;
  logic [3:0]  mask;
  mem_req_t    cur;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Byte lanes touched by a store of this size at this offset
  function automatic logic [3:0] store_lanes(input size_t size, input logic [1:0] off);
    if (size == SIZE_BYTE) begin
      return 4'b0001 << off;
    end else if (size == SIZE_HALF) begin
      return off[1] ? 4'b1100 : 4'b0011;
    end
    return 4'b1111;
  endfunction

  initial begin
    rng = 32'h46d1;
    for (int i = 0; i < 1024; i++) begin
      store[i] = ((32'h0004_0000 + i * 4) * 32'h9e3779b1) ^ 32'h2c1b3a5f;
    end
  end

  // Line reads come back in word order
  assign beat_word = 2'(3'd4 - left);

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem_rsp <= '0;
      busy    <= 1'b0;
      left    <= '0;
      gap     <= '0;
    end else begin
      mem_rsp.beat <= 1'b0;
      rng = lcg_next(rng);
      if (!busy) begin
        if (mem_req.req) begin
          cur  <= mem_req;
          busy <= 1'b1;
          left <= mem_req.write ? 3'd1 : 3'd4;
          gap  <= rng[17:16];
        end
      end else if (gap != 2'd0) begin
        gap <= gap - 2'd1;
      end else begin
        mem_rsp.beat <= 1'b1;
        if (cur.write) begin
          mask = store_lanes(cur.size, cur.addr[1:0]);
          for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
              store[cur.addr[11:2]][b*8 +: 8] = cur.wdata[b*8 +: 8];
            end
          end
          mem_rsp.rdata <= '0;
        end else begin
          mem_rsp.rdata <= store[{cur.addr[11:4], beat_word}];
        end
        left <= left - 3'd1;
        gap  <= rng[17:16];
        if (left == 3'd1) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

/* verification/dcache_assert.sv */
`timescale 1ns/100ps

module dcache_assert
  import dcache_pkg::*;
(
  input logic     clk,
  input logic     rstn,
  input logic     core_wait,
  input mem_req_t mem_req,
  input mem_rsp_t mem_rsp
);

  a_wait_in_reset: assert property (@(posedge clk) !rstn |-> !core_wait)
    else $error("core_wait high during reset");

  a_req_held: assert property (@(posedge clk) disable iff (!rstn)
    mem_req.req |=> mem_req.req || mem_rsp.beat)
    else $error("mem req dropped before a beat");

  a_fields_stable: assert property (@(posedge clk) disable iff (!rstn)
    mem_req.req && !mem_rsp.beat |=>
      $stable({mem_req.write, mem_req.addr, mem_req.wdata, mem_req.size}))
    else $error("mem fields changed while req held");

  a_req_in_wait: assert property (@(posedge clk) disable iff (!rstn)
    mem_req.req |-> core_wait)
    else $error("mem req high while core_wait low");

endmodule

bind dcache_top dcache_assert u_assert (
  .clk       (clk),
  .rstn      (rstn),
  .core_wait (core_wait),
  .mem_req   (mem_req),
  .mem_rsp   (mem_rsp)
);

/* verification/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb
  import dcache_pkg::*;
();

  logic              clk;
  logic              rstn;
  logic              core_req;
  core_cmd_t         core_cmd;
  logic              core_wait;
  logic [DATA_W-1:0] core_rdata;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;
  dcache_stats_t     stats;

  logic [31:0] rng;
  logic [31:0] model_mem [1024];
  tag_t        model_tag [LINES];
  logic        model_valid [LINES];
  int          exp_rh, exp_wh, exp_rm, exp_wm;
  int          errors, fails;
  int          n_wr, n_rd, n_beats;
  logic        req_seen;
  mem_req_t    last_req;

  dcache_top DUT (
    .clk(clk), .rstn(rstn), .core_req(core_req), .core_cmd(core_cmd),
    .core_wait(core_wait), .core_rdata(core_rdata), .mem_req(mem_req),
    .mem_rsp(mem_rsp), .stats(stats)
  );

  dcache_tb_mem u_mem (.clk(clk), .rstn(rstn), .mem_req(mem_req), .mem_rsp(mem_rsp));

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [3:0] store_lanes(input size_t size, input logic [1:0] off);
    if (size == SIZE_BYTE) begin
      return 4'b0001 << off;
    end else if (size == SIZE_HALF) begin
      return off[1] ? 4'b1100 : 4'b0011;
    end
    return 4'b1111;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Memory traffic seen on the bus and counted per request
  always @(negedge clk) begin
    if (rstn && mem_req.req && !req_seen) begin
      last_req = mem_req;
      if (mem_req.write) n_wr++;
      else n_rd++;
    end
    if (rstn && mem_rsp.beat) n_beats++;
    req_seen = mem_req.req;
  end

  task automatic run_request(input logic [31:0] addr, input logic write,
                             input logic [31:0] wdata, input size_t size);
    int          wr0, rd0, bt0, cycles;
    logic [4:0]  idx;
    logic [9:0]  widx;
    logic        hit;
    logic [3:0]  mask;
    wr0    = n_wr;
    rd0    = n_rd;
    bt0    = n_beats;
    cycles = 0;
    idx    = addr[8:4];
    widx   = addr[11:2];
    hit    = model_valid[idx] && (model_tag[idx] == addr[31:9]);
    @(posedge clk);
    core_req <= 1'b1;
    core_cmd <= '{addr: addr, write: write, wdata: wdata, size: size};
    @(posedge clk);
    core_req <= 1'b0;
    do begin
      @(negedge clk);
      cycles++;
    end while (core_wait);
    if (!write) begin
      check_value("core_rdata", model_mem[widx], core_rdata);
      if (hit) begin
        exp_rh++;
        if (cycles != 2 || n_rd != rd0) begin
          $display("Load hit at %h took %0d wait cycles or touched memory", addr, cycles - 1);
          fails++;
        end
      end else begin
        exp_rm++;
        model_valid[idx] = 1'b1;
        model_tag[idx]   = addr[31:9];
        if (n_rd != rd0 + 1 || n_beats != bt0 + 4 || n_wr != wr0) begin
          $display("Load miss at %h did not issue one four-beat line read", addr);
          fails++;
        end else begin
          check_value("mem_req.addr", {addr[31:4], 4'h0}, last_req.addr);
        end
      end
    end else begin
      if (hit) exp_wh++;
      else exp_wm++;
      mask = store_lanes(size, addr[1:0]);
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) model_mem[widx][b*8 +: 8] = wdata[b*8 +: 8];
      end
      if (n_wr != wr0 + 1 || n_beats != bt0 + 1 || n_rd != rd0) begin
        $display("Store at %h did not issue exactly one memory write", addr);
        fails++;
      end else begin
        check_value("mem_req.addr", addr, last_req.addr);
        check_value("mem_req.wdata", wdata, last_req.wdata);
        check_value("mem_req.size", {30'h0, size}, {30'h0, last_req.size});
      end
    end
  endtask

  initial begin
    #(400 * 40 * 8);
    $display("Timeout: the request stream did not complete");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int          kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    size_t       size;
    clk      = 1'b0;
    rstn     = 1'b0;
    core_req = 1'b0;
    core_cmd = '0;
    req_seen = 1'b0;
    rng      = 32'h46d1;
    for (int i = 0; i < 1024; i++) begin
      model_mem[i] = ((32'h0004_0000 + i * 4) * 32'h9e3779b1) ^ 32'h2c1b3a5f;
    end
    for (int i = 0; i < LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    // Stream of 400 requests over a 4 KB window with 60 percent loads
    for (int n = 0; n < 400; n++) begin
      rng   = lcg_next(rng);
      kind  = rng[31:16] % 100;
      rng   = lcg_next(rng);
      addr  = 32'h0004_0000 | {20'h0, rng[27:16]};
      rng   = lcg_next(rng);
      size  = rng[17:16] % 2'd3;
      rng   = lcg_next(rng);
      wdata[31:16] = rng[31:16];
      rng   = lcg_next(rng);
      wdata[15:0]  = rng[31:16];
      if (kind < 60 || size == SIZE_WORD) addr[1:0] = 2'b00;
      else if (size == SIZE_HALF) addr[0] = 1'b0;
      run_request(addr, kind >= 60, wdata, kind < 60 ? SIZE_WORD : size);
    end
    check_value("stats.read_hits", 32'(exp_rh), {16'h0, stats.read_hits});
    check_value("stats.write_hits", 32'(exp_wh), {16'h0, stats.write_hits});
    check_value("stats.read_misses", 32'(exp_rm), {16'h0, stats.read_misses});
    check_value("stats.write_misses", 32'(exp_wm), {16'h0, stats.write_misses});
    $display("Errors: %0d wrong values, %0d other failures", errors, fails);
    if (errors + fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/dcache_pkg.sv
rtl/dcache_array.sv
rtl/dcache_req_decode.sv
rtl/dcache_ctrl.sv
rtl/dcache_result.sv
rtl/dcache_top.sv
verification/dcache_tb_mem.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

/* run.sh */
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module dcache_tb -o dcache_sim
obj_dir/dcache_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
